//--- common/msadc_pkg.sv
// multi-slope adc shared definitions
// widths, register map, timing constants, sequencer states and bundled types
`default_nettype none

package msadc_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths

  localparam int FRAME_BITS = 32;
  localparam int ADDR_BITS  = 8;
  localparam int WORD_BITS  = FRAME_BITS - ADDR_BITS;

  // register payload, always 24 bits on the wire
  typedef logic [WORD_BITS-1:0] word_t;
  // msb set means read only, the frame writes nothing
  typedef logic [ADDR_BITS-1:0] addr_t;
  typedef logic [WORD_BITS-1:0] count_t;

  // integrator switch select {sig, neg, pos}
  typedef logic [2:0] ref_sel_t;

  localparam ref_sel_t REF_IDLE = 3'b000;
  localparam ref_sel_t REF_POS  = 3'b001;
  localparam ref_sel_t REF_NEG  = 3'b010;

  ////////////////////////////////////////////////////////////////////////////
  // register map

  localparam addr_t ADDR_CTRL    = 8'd7;
  localparam addr_t ADDR_NPHASE  = 8'd8;
  localparam addr_t ADDR_UP      = 8'd9;
  localparam addr_t ADDR_DOWN    = 8'd10;
  // write here acts as soft reset, read gives the rundown count
  localparam addr_t ADDR_RUNDOWN = 8'd11;

  localparam word_t  CTRL_RESET   = 24'd0;
  localparam count_t NPHASE_RESET = 24'd20;

  ////////////////////////////////////////////////////////////////////////////
  // timing, all in clk cycles

  localparam count_t SETTLE_CYCLES = 24'd16;
  localparam count_t PHASE_CYCLES  = 24'd32;
  // give up on a comparator that never crosses
  localparam count_t RUNDOWN_MAX   = 24'd4095;

  typedef enum logic [1:0] {
    init,
    runup,
    rundown,
    done
  } seq_state_t;

  // results of one conversion
  typedef struct packed {
    count_t up;
    count_t down;
    count_t rundown;
  } conv_counts_t;

  // one-cycle write request from the serial port
  typedef struct packed {
    logic  valid;
    addr_t addr;
    word_t data;
  } reg_wr_t;

  // control register layout, upper bits read back as zero
  typedef struct packed {
    logic [WORD_BITS-5:0] rsvd;
    logic [2:0]           user;
    logic                 run_en;
  } ctrl_t;

endpackage

`default_nettype wire

//--- src/cmp_sync.sv
// comparator synchronizer
// brings the comparator pin into the clk domain and flags zero crossings
`default_nettype none

module cmp_sync (
  input  logic clk,
  input  logic reset,
  input  logic cmp_in,
  output logic cmp_level,
  output logic cmp_cross
);

  // history, bit 0 is the newest sample
  logic [2:0] hist;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      // all zero so the first samples after reset don't look like an edge
      hist <= '0;
    end
    else
    begin
      hist <= {hist[1:0], cmp_in};
    end
  end

  // oldest stage is the settled level
  assign cmp_level = hist[2];

  // either direction counts as a crossing
  assign cmp_cross = hist[2] ^ hist[1];

endmodule

`default_nettype wire

//--- src/phase_counters.sv
// conversion counters
// counts run-up phases per direction and rundown cycles, latched at conversion end
`default_nettype none

module phase_counters (
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    clear,
  input  logic                    phase_up,
  input  logic                    phase_down,
  input  logic                    rundown_tick,
  input  logic                    latch,
  output msadc_pkg::conv_counts_t counts
);

  // running values for the conversion in progress
  msadc_pkg::count_t up_cnt;
  msadc_pkg::count_t down_cnt;
  msadc_pkg::count_t rundown_cnt;

  always_ff @(posedge clk)
  begin
    if (reset || clear)
    begin
      up_cnt      <= '0;
      down_cnt    <= '0;
      rundown_cnt <= '0;
    end
    else
    begin
      // up means the negative ref was switched in for the next phase
      if (phase_up)
      begin
        up_cnt <= up_cnt + 1'b1;
      end
      if (phase_down)
      begin
        down_cnt <= down_cnt + 1'b1;
      end
      if (rundown_tick)
      begin
        rundown_cnt <= rundown_cnt + 1'b1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // result copy, stable between conversions so reads never tear

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      counts <= '0;
    end
    else if (latch)
    begin
      counts.up      <= up_cnt;
      counts.down    <= down_cnt;
      counts.rundown <= rundown_cnt;
    end
  end

  // the sequencer picks one direction per phase end
  assert property (@(posedge clk) disable iff (reset)
    !(phase_up && phase_down));

endmodule

`default_nettype wire

//--- src/msadc_sequencer.sv
// multi-slope conversion sequencer
// settle, fixed-length run-up phases, rundown to zero cross, then done with irq
`default_nettype none

module msadc_sequencer (
  input  logic                clk,
  input  logic                reset,
  input  logic                run_en,
  input  msadc_pkg::count_t   nphase,
  input  logic                cmp_level,
  input  logic                cmp_cross,
  output msadc_pkg::ref_sel_t ref_sel,
  output logic                irq,
  output logic                clear,
  output logic                phase_up,
  output logic                phase_down,
  output logic                rundown_tick,
  output logic                latch
);

  msadc_pkg::seq_state_t state;

  // clk cycles within the current state or phase
  msadc_pkg::count_t cyc_cnt;
  // run-up phases finished so far
  msadc_pkg::count_t phase_cnt;

  logic settle_end;
  logic phase_end;
  logic rundown_end;
  logic last_phase;

  ////////////////////////////////////////////////////////////////////////////
  // decode

  assign settle_end = (state == msadc_pkg::init) && run_en &&
                      (cyc_cnt == msadc_pkg::SETTLE_CYCLES - 1'b1);

  assign phase_end = (state == msadc_pkg::runup) &&
                     (cyc_cnt == msadc_pkg::PHASE_CYCLES - 1'b1);

  // >= so a zero nphase still gives a single phase instead of a hang
  assign last_phase = (msadc_pkg::count_t'(phase_cnt + 1'b1) >= nphase);

  // timeout covers a comparator stuck on one side
  assign rundown_end = (state == msadc_pkg::rundown) &&
                       (cmp_cross || (cyc_cnt == msadc_pkg::RUNDOWN_MAX - 1'b1));

  // counter strobes
  assign clear        = settle_end;
  assign phase_up     = phase_end && cmp_level;
  assign phase_down   = phase_end && !cmp_level;
  assign rundown_tick = (state == msadc_pkg::rundown);
  assign latch        = (state == msadc_pkg::done);
  assign irq          = (state == msadc_pkg::done);

  ////////////////////////////////////////////////////////////////////////////
  // state machine

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state     <= msadc_pkg::init;
      cyc_cnt   <= '0;
      phase_cnt <= '0;
      ref_sel   <= msadc_pkg::REF_IDLE;
    end
    else
    begin
      case (state)
        msadc_pkg::init:
        begin
          if (!run_en)
          begin
            cyc_cnt <= '0;
          end
          else if (settle_end)
          begin
            state     <= msadc_pkg::runup;
            cyc_cnt   <= '0;
            phase_cnt <= '0;
            // first phase direction from the comparator, not counted
            ref_sel   <= cmp_level ? msadc_pkg::REF_NEG : msadc_pkg::REF_POS;
          end
          else
          begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end

        msadc_pkg::runup:
        begin
          if (phase_end)
          begin
            cyc_cnt   <= '0;
            phase_cnt <= phase_cnt + 1'b1;
            // integrator above zero, pull it down
            ref_sel   <= cmp_level ? msadc_pkg::REF_NEG : msadc_pkg::REF_POS;
            if (last_phase)
            begin
              // last select stays on for the rundown
              state <= msadc_pkg::rundown;
            end
          end
          else
          begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end

        msadc_pkg::rundown:
        begin
          if (rundown_end)
          begin
            state   <= msadc_pkg::done;
            cyc_cnt <= '0;
            ref_sel <= msadc_pkg::REF_IDLE;
          end
          else
          begin
            cyc_cnt <= cyc_cnt + 1'b1;
          end
        end

        msadc_pkg::done:
        begin
          state   <= msadc_pkg::init;
          cyc_cnt <= '0;
        end

        default:
        begin
          state <= msadc_pkg::init;
        end
      endcase
    end
  end

  // both refs at once would short the references
  assert property (@(posedge clk) disable iff (reset)
    !(ref_sel[0] && ref_sel[1]));

  assert property (@(posedge clk) disable iff (reset)
    irq |=> !irq);

endmodule

`default_nettype wire

//--- spi_regs/spi_frame.sv
// serial slave framer
// oversampled sck, 8-bit address then 24-bit value, read reply after bit 8
`default_nettype none

module spi_frame (
  input  logic               clk,
  input  logic               reset,
  input  logic               sck,
  input  logic               cs_n,
  input  logic               sdi,
  output logic               sdo,
  output logic               rd_req,
  output msadc_pkg::addr_t   rd_addr,
  input  msadc_pkg::word_t   rd_data,
  output msadc_pkg::reg_wr_t wr
);

  // two-flop synchronizers plus one delayed copy for edges
  logic [1:0] sck_sync;
  logic [1:0] cs_sync;
  logic [1:0] sdi_sync;
  logic       sck_prev;
  logic       cs_prev;

  logic       cs_active;
  logic       sck_rise;
  logic       cs_rise;

  logic [msadc_pkg::FRAME_BITS-1:0] shift_in;
  msadc_pkg::word_t                 shift_out;
  // 0 to FRAME_BITS
  logic [5:0]                       bit_cnt;
  logic                             overrun;
  logic                             ld_reply;
  logic                             wr_valid;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      sck_sync <= '0;
      cs_sync  <= '1;
      sdi_sync <= '0;
      sck_prev <= 1'b0;
      cs_prev  <= 1'b1;
    end
    else
    begin
      sck_sync <= {sck_sync[0], sck};
      cs_sync  <= {cs_sync[0], cs_n};
      sdi_sync <= {sdi_sync[0], sdi};
      sck_prev <= sck_sync[1];
      cs_prev  <= cs_sync[1];
    end
  end

  assign cs_active = !cs_sync[1];
  assign sck_rise  = cs_active && sck_sync[1] && !sck_prev;
  assign cs_rise   = cs_sync[1] && !cs_prev;

  ////////////////////////////////////////////////////////////////////////////
  // frame control

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      bit_cnt  <= '0;
      overrun  <= 1'b0;
      rd_req   <= 1'b0;
      ld_reply <= 1'b0;
      sdo      <= 1'b0;
      wr_valid <= 1'b0;
    end
    else
    begin
      rd_req   <= 1'b0;
      ld_reply <= rd_req;
      // full length write frame only, uses the count before it clears
      wr_valid <= cs_rise && (bit_cnt == msadc_pkg::FRAME_BITS) && !overrun &&
                  !shift_in[msadc_pkg::FRAME_BITS-1];
      if (!cs_active)
      begin
        bit_cnt <= '0;
        overrun <= 1'b0;
        sdo     <= 1'b0;
      end
      else if (sck_rise)
      begin
        // extra bits poison the frame instead of wrapping
        if (bit_cnt == msadc_pkg::FRAME_BITS)
        begin
          overrun <= 1'b1;
        end
        else
        begin
          bit_cnt <= bit_cnt + 1'b1;
        end
        // address complete with this bit
        if (bit_cnt == msadc_pkg::ADDR_BITS - 1)
        begin
          rd_req <= 1'b1;
        end
        // reply msb goes out on bit 9
        if ((bit_cnt >= msadc_pkg::ADDR_BITS) && (bit_cnt < msadc_pkg::FRAME_BITS))
        begin
          sdo <= shift_out[msadc_pkg::WORD_BITS-1];
        end
      end
    end
  end

  // data path
  always_ff @(posedge clk)
  begin
    if (sck_rise)
    begin
      shift_in <= {shift_in[msadc_pkg::FRAME_BITS-2:0], sdi_sync[1]};
      if (bit_cnt >= msadc_pkg::ADDR_BITS)
      begin
        shift_out <= shift_out << 1;
      end
    end
    if (ld_reply)
    begin
      shift_out <= rd_data;
    end
  end

  // read bit dropped so reads and writes share the map
  assign rd_addr = {1'b0, shift_in[msadc_pkg::ADDR_BITS-2:0]};

  // shift_in holds still between cs_n rising and the next frame
  assign wr = '{valid: wr_valid,
                addr:  shift_in[msadc_pkg::FRAME_BITS-1 -: msadc_pkg::ADDR_BITS],
                data:  shift_in[msadc_pkg::WORD_BITS-1:0]};

  assert property (@(posedge clk) disable iff (reset)
    bit_cnt <= msadc_pkg::FRAME_BITS);

endmodule

`default_nettype wire

//--- spi_regs/reg_bank.sv
// adc register bank
// control and phase-count registers, soft reset, read mux with latched counts
`default_nettype none

module reg_bank (
  input  msadc_pkg::reg_wr_t      wr,
  input  logic                    clk,
  input  logic                    reset,
  input  logic                    rd_req,
  input  msadc_pkg::addr_t        rd_addr,
  output msadc_pkg::word_t        rd_data,
  input  msadc_pkg::conv_counts_t counts,
  output logic                    run_en,
  output msadc_pkg::count_t       nphase,
  output logic [2:0]              user_bits
);

  msadc_pkg::ctrl_t  ctrl_q;
  msadc_pkg::count_t nphase_q;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      ctrl_q   <= msadc_pkg::ctrl_t'(msadc_pkg::CTRL_RESET);
      nphase_q <= msadc_pkg::NPHASE_RESET;
    end
    else if (wr.valid)
    begin
      case (wr.addr)
        msadc_pkg::ADDR_CTRL:
        begin
          // reserved bits stay zero
          ctrl_q <= '{rsvd: '0, user: wr.data[3:1], run_en: wr.data[0]};
        end
        msadc_pkg::ADDR_NPHASE:
        begin
          nphase_q <= wr.data;
        end
        msadc_pkg::ADDR_RUNDOWN:
        begin
          // soft reset, also drops run enable
          ctrl_q   <= msadc_pkg::ctrl_t'(msadc_pkg::CTRL_RESET);
          nphase_q <= msadc_pkg::NPHASE_RESET;
        end
        default:
        begin
        end
      endcase
    end
  end

  // reply one cycle after the request
  always_ff @(posedge clk)
  begin
    if (rd_req)
    begin
      case (rd_addr)
        msadc_pkg::ADDR_CTRL:    rd_data <= msadc_pkg::word_t'(ctrl_q);
        msadc_pkg::ADDR_NPHASE:  rd_data <= nphase_q;
        msadc_pkg::ADDR_UP:      rd_data <= counts.up;
        msadc_pkg::ADDR_DOWN:    rd_data <= counts.down;
        msadc_pkg::ADDR_RUNDOWN: rd_data <= counts.rundown;
        default:                 rd_data <= '0;
      endcase
    end
  end

  assign run_en    = ctrl_q.run_en;
  assign nphase    = nphase_q;
  assign user_bits = ctrl_q.user;

endmodule

`default_nettype wire

//--- src/msadc_top.sv
// multi-slope adc controller top
// sequencer, comparator sync, counters and serial register port
`default_nettype none

module msadc_top (
  input  logic                clk,
  input  logic                reset,
  input  logic                cmp_in,
  input  logic                sck,
  input  logic                cs_n,
  input  logic                sdi,
  output logic                sdo,
  output msadc_pkg::ref_sel_t ref_sel,
  output logic                irq,
  output logic [2:0]          user_bits
);

  logic cmp_level;
  logic cmp_cross;

  // sequencer to counters
  logic clear;
  logic phase_up;
  logic phase_down;
  logic rundown_tick;
  logic latch;

  msadc_pkg::conv_counts_t counts;
  logic                    run_en;
  msadc_pkg::count_t       nphase;

  // serial port to registers
  msadc_pkg::reg_wr_t wr;
  logic               rd_req;
  msadc_pkg::addr_t   rd_addr;
  msadc_pkg::word_t   rd_data;

  ////////////////////////////////////////////////////////////////////////////
  // conversion path

  cmp_sync i_cmp_sync (
    .clk       (clk),
    .reset     (reset),
    .cmp_in    (cmp_in),
    .cmp_level (cmp_level),
    .cmp_cross (cmp_cross)
  );

  msadc_sequencer i_msadc_sequencer (
    .clk          (clk),
    .reset        (reset),
    .run_en       (run_en),
    .nphase       (nphase),
    .cmp_level    (cmp_level),
    .cmp_cross    (cmp_cross),
    .ref_sel      (ref_sel),
    .irq          (irq),
    .clear        (clear),
    .phase_up     (phase_up),
    .phase_down   (phase_down),
    .rundown_tick (rundown_tick),
    .latch        (latch)
  );

  phase_counters i_phase_counters (
    .clk          (clk),
    .reset        (reset),
    .clear        (clear),
    .phase_up     (phase_up),
    .phase_down   (phase_down),
    .rundown_tick (rundown_tick),
    .latch        (latch),
    .counts       (counts)
  );

  ////////////////////////////////////////////////////////////////////////////
  // register port

  spi_frame i_spi_frame (
    .clk     (clk),
    .reset   (reset),
    .sck     (sck),
    .cs_n    (cs_n),
    .sdi     (sdi),
    .sdo     (sdo),
    .rd_req  (rd_req),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .wr      (wr)
  );

  reg_bank i_reg_bank (
    .clk       (clk),
    .reset     (reset),
    .wr        (wr),
    .rd_req    (rd_req),
    .rd_addr   (rd_addr),
    .rd_data   (rd_data),
    .counts    (counts),
    .run_en    (run_en),
    .nphase    (nphase),
    .user_bits (user_bits)
  );

endmodule

`default_nettype wire

//--- verif/tb_msadc_top.sv
// testbench for the multi-slope adc controller
// integrator model, serial master, table of conversions checked against charge balance
`default_nettype none

module tb_msadc_top;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int R = 64;
  localparam int HALF_SCK = 4;
  localparam int QUIET_CYCLES = 24;
  localparam int NROWS = 4;

  typedef struct packed {
    logic signed [15:0] u;
    msadc_pkg::count_t  nphase;
    logic [2:0]         user;
  } row_t;

  logic clk = 1'b0;
  logic reset;
  logic cmp_in;
  logic sck;
  logic cs_n;
  logic sdi;
  logic sdo;
  msadc_pkg::ref_sel_t ref_sel;
  logic irq;
  logic [2:0] user_bits;

  row_t rows [NROWS];
  int   u_in = 0;
  int   sum = 0;
  int   irq_count = 0;
  int   errors = 0;
  int   tests = 0;
  int   failed_tests = 0;
  int   test_err_start = 0;
  int   cycles = 0;
  int   limit = 1000000;

  msadc_top i_msadc_top (
    .clk       (clk),
    .reset     (reset),
    .cmp_in    (cmp_in),
    .sck       (sck),
    .cs_n      (cs_n),
    .sdi       (sdi),
    .sdo       (sdo),
    .ref_sel   (ref_sel),
    .irq       (irq),
    .user_bits (user_bits)
  );

  always #4 clk = ~clk;

  ////////////////////////////////////////////////////////////////////////////
  // integrator model that holds its charge while the switches are open

  always @(posedge clk)
  begin
    #1;
    if (ref_sel != msadc_pkg::REF_IDLE)
    begin
      sum = sum + u_in;
      if (ref_sel == msadc_pkg::REF_NEG)
      begin
        sum = sum - R;
      end
      else if (ref_sel == msadc_pkg::REF_POS)
      begin
        sum = sum + R;
      end
    end
    cmp_in = (sum > 0);
  end

  // irq monitor sampled mid cycle
  always @(negedge clk)
  begin
    if (!reset && irq)
    begin
      irq_count = irq_count + 1;
      check_sel("ref_sel during irq", ref_sel, msadc_pkg::REF_IDLE);
    end
  end

  // watchdog
  always @(posedge clk)
  begin
    cycles = cycles + 1;
    if (cycles >= limit)
    begin
      $display("timeout after %0d cycles, DUT stopped responding", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // compare tasks

  task automatic check_word(input string name, input msadc_pkg::word_t got,
                            input msadc_pkg::word_t exp);
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("mismatch %s: got 0x%06h expected 0x%06h", name, got, exp);
    end
  endtask

  task automatic check_sel(input string name, input msadc_pkg::ref_sel_t got,
                           input msadc_pkg::ref_sel_t exp);
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic check_irq(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      errors = errors + 1;
      $display("mismatch %s: got 0x%0h expected 0x%0h", name, got, exp);
    end
  endtask

  task automatic report_test(input string name);
    tests = tests + 1;
    if (errors == test_err_start)
    begin
      $display("test %0d %s: ok", tests, name);
    end
    else
    begin
      failed_tests = failed_tests + 1;
      $display("test %0d %s: %0d errors", tests, name, errors - test_err_start);
    end
    test_err_start = errors;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // timing helpers and serial master

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk);
    #1;
  endtask

  task automatic wait_irq();
    int start;
    start = irq_count;
    while (irq_count == start)
    begin
      wait_cycles(1);
    end
  endtask

  // sequencer back in init once the switches stay open longer than a settle
  task automatic wait_idle();
    int n;
    n = 0;
    while (n < QUIET_CYCLES)
    begin
      wait_cycles(1);
      if (ref_sel == msadc_pkg::REF_IDLE)
      begin
        n = n + 1;
      end
      else
      begin
        n = 0;
      end
    end
  endtask

  // nbits below 32 gives a frame cut short by cs_n
  task automatic xfer(input msadc_pkg::addr_t a, input msadc_pkg::word_t d,
                      input int nbits, output msadc_pkg::word_t rx);
    logic [31:0] tx;
    tx = {a, d};
    rx = '0;
    cs_n = 1'b0;
    wait_cycles(4);
    for (int i = 0; i < nbits; i++)
    begin
      sdi = tx[31-i];
      sck = 1'b0;
      wait_cycles(HALF_SCK);
      sck = 1'b1;
      wait_cycles(HALF_SCK);
      // reply bits settle within the high half
      if (i >= 8)
      begin
        rx = {rx[22:0], sdo};
      end
    end
    sck = 1'b0;
    wait_cycles(HALF_SCK);
    cs_n = 1'b1;
    wait_cycles(8);
  endtask

  task automatic write_reg(input msadc_pkg::addr_t a, input msadc_pkg::word_t d);
    msadc_pkg::word_t unused_rx;
    xfer(a, d, 32, unused_rx);
  endtask

  task automatic read_reg(input msadc_pkg::addr_t a, output msadc_pkg::word_t d);
    xfer(a | 8'h80, '0, 32, d);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // one conversion row with the reads in random order

  task automatic run_row(input row_t row);
    msadc_pkg::addr_t order [3];
    msadc_pkg::addr_t tmp;
    msadc_pkg::word_t val;
    msadc_pkg::word_t up_v;
    msadc_pkg::word_t down_v;
    msadc_pkg::word_t rd_v;
    int j;
    int lhs;
    int rhs;
    order[0] = msadc_pkg::ADDR_UP;
    order[1] = msadc_pkg::ADDR_DOWN;
    order[2] = msadc_pkg::ADDR_RUNDOWN;
    up_v = '0;
    down_v = '0;
    rd_v = '0;
    u_in = int'(row.u);
    sum = 0;
    write_reg(msadc_pkg::ADDR_NPHASE, row.nphase);
    write_reg(msadc_pkg::ADDR_CTRL, msadc_pkg::word_t'({row.user, 1'b1}));
    wait_irq();
    // stop further conversions so the latched counts hold still
    write_reg(msadc_pkg::ADDR_CTRL, msadc_pkg::word_t'({row.user, 1'b0}));
    wait_idle();
    check_word("user_bits", msadc_pkg::word_t'(user_bits), msadc_pkg::word_t'(row.user));
    for (int k = 2; k > 0; k--)
    begin
      j = int'($urandom % (k + 1));
      tmp = order[k];
      order[k] = order[j];
      order[j] = tmp;
    end
    for (int k = 0; k < 3; k++)
    begin
      read_reg(order[k], val);
      if (order[k] == msadc_pkg::ADDR_UP)
      begin
        up_v = val;
      end
      else if (order[k] == msadc_pkg::ADDR_DOWN)
      begin
        down_v = val;
      end
      else
      begin
        rd_v = val;
      end
    end
    check_word("up+down", up_v + down_v, row.nphase);
    lhs = (int'(up_v) - int'(down_v)) * R * int'(msadc_pkg::PHASE_CYCLES);
    rhs = int'(row.u) * int'(row.nphase) * int'(msadc_pkg::PHASE_CYCLES);
    if (lhs - rhs > 2 * R * int'(msadc_pkg::PHASE_CYCLES) ||
        rhs - lhs > 2 * R * int'(msadc_pkg::PHASE_CYCLES))
    begin
      errors = errors + 1;
      $display("charge balance off: up %0d down %0d for u %0d", up_v, down_v, row.u);
    end
    if (rd_v == '0 || rd_v > msadc_pkg::RUNDOWN_MAX)
    begin
      errors = errors + 1;
      $display("rundown count %0d outside 1 to %0d", rd_v, msadc_pkg::RUNDOWN_MAX);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // main sequence

  initial
  begin
    msadc_pkg::word_t val;
    int quiet_start;
    reset = 1'b1;
    cmp_in = 1'b0;
    sck = 1'b0;
    cs_n = 1'b1;
    sdi = 1'b0;
    void'($urandom(32'h7883c21d));
    rows[0] = '{u: 16'sd0,   nphase: 24'd20, user: 3'd1};
    rows[1] = '{u: 16'sd24,  nphase: 24'd16, user: 3'd6};
    rows[2] = '{u: -16'sd16, nphase: 24'd12, user: 3'd2};
    rows[3] = '{u: 16'sd28,  nphase: 24'd10, user: 3'd7};
    // per row a settle, the run-up, a full rundown and six frames
    limit = 0;
    for (int i = 0; i < NROWS; i++)
    begin
      limit = limit + int'(msadc_pkg::SETTLE_CYCLES) +
              int'(rows[i].nphase) * int'(msadc_pkg::PHASE_CYCLES) +
              int'(msadc_pkg::RUNDOWN_MAX) + 6 * 256;
    end
    limit = 2 * limit;
    repeat (8) @(posedge clk);
    #1;
    reset = 1'b0;
    wait_cycles(4);

    check_sel("ref_sel", ref_sel, msadc_pkg::REF_IDLE);
    check_irq("irq", irq, 1'b0);
    read_reg(msadc_pkg::ADDR_CTRL, val);
    check_word("ctrl", val, msadc_pkg::CTRL_RESET);
    read_reg(msadc_pkg::ADDR_NPHASE, val);
    check_word("nphase", val, msadc_pkg::NPHASE_RESET);
    read_reg(msadc_pkg::ADDR_UP, val);
    check_word("up", val, '0);
    read_reg(msadc_pkg::ADDR_DOWN, val);
    check_word("down", val, '0);
    read_reg(msadc_pkg::ADDR_RUNDOWN, val);
    check_word("rundown", val, '0);
    report_test("reset values");

    // reserved bits of the control register read back as zero
    write_reg(msadc_pkg::ADDR_CTRL, 24'hfff00a);
    read_reg(msadc_pkg::ADDR_CTRL, val);
    check_word("ctrl", val, 24'h00000a);
    check_word("user_bits", msadc_pkg::word_t'(user_bits), 24'h5);
    write_reg(msadc_pkg::ADDR_NPHASE, 24'h000123);
    xfer(msadc_pkg::ADDR_NPHASE | 8'h80, 24'h000777, 32, val);
    check_word("nphase read frame", val, 24'h000123);
    read_reg(msadc_pkg::ADDR_NPHASE, val);
    check_word("nphase", val, 24'h000123);
    report_test("register write and read");

    xfer(msadc_pkg::ADDR_NPHASE, 24'h000055, 20, val);
    read_reg(msadc_pkg::ADDR_NPHASE, val);
    check_word("nphase after short frame", val, 24'h000123);
    report_test("short frame");

    for (int i = 0; i < NROWS; i++)
    begin
      run_row(rows[i]);
      report_test($sformatf("conversion row %0d", i));
    end

    write_reg(msadc_pkg::ADDR_CTRL, 24'h000001);
    wait_irq();
    write_reg(msadc_pkg::ADDR_RUNDOWN, '0);
    read_reg(msadc_pkg::ADDR_CTRL, val);
    check_word("ctrl", val, msadc_pkg::CTRL_RESET);
    read_reg(msadc_pkg::ADDR_NPHASE, val);
    check_word("nphase", val, msadc_pkg::NPHASE_RESET);
    wait_idle();
    quiet_start = irq_count;
    // long enough for a whole conversion at the reset phase count
    wait_cycles(int'(msadc_pkg::SETTLE_CYCLES) +
                int'(msadc_pkg::NPHASE_RESET) * int'(msadc_pkg::PHASE_CYCLES) +
                int'(msadc_pkg::RUNDOWN_MAX));
    check_irq("irq", irq, 1'b0);
    if (irq_count != quiet_start)
    begin
      errors = errors + 1;
      $display("conversion finished after soft reset");
    end
    report_test("soft reset");

    $display("tests %0d, failed %0d, errors %0d", tests, failed_tests, errors);
    if (errors == 0)
    begin
      $display("TESTBENCH PASSED");
    end
    else
    begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- list.f
common/msadc_pkg.sv
src/cmp_sync.sv
src/phase_counters.sv
src/msadc_sequencer.sv
spi_regs/spi_frame.sv
spi_regs/reg_bank.sv
src/msadc_top.sv
verif/tb_msadc_top.sv

//--- run_sim.sh
#!/bin/sh
# build and run the msadc testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module tb_msadc_top \
  -f list.f \
  -o sim_msadc

out=$(./obj_dir/sim_msadc)
echo "$out"

# grep returns non-zero when the pass line is missing, set -e turns that into failure
echo "$out" | grep -q "^TESTBENCH PASSED$"
